// File: mipsProcessor.f
+incdir+bench
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/memPort.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/dataPath.sv
rtl/mipsProcessor.sv
bench/mipsProcessorTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module mipsProcessorTb -f mipsProcessor.f -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1

// File: bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [15:0] lfsrState = 16'd98;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

function automatic logic [31:0] takeBits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		lfsrState = lfsrStep(lfsrState);
		bits = {bits[30:0], lfsrState[0]};	// One step per bit
	end
	return bits;
endfunction

function automatic dataWord encR(input functField fn, input regAddr rd, input regAddr rs,
	input regAddr rt);
	return {opRType, rs, rt, rd, 5'd0, fn};
endfunction

function automatic dataWord encI(input opcodeField op, input regAddr rt, input regAddr rs,
	input immField imm);
	return {op, rs, rt, imm};
endfunction

// Expected ALU result of one instruction
function automatic dataWord refAlu(input opcodeField op, input functField fn, input dataWord a,
	input dataWord b, input immField imm);
	dataWord sImm;
	dataWord zImm;
	sImm = {{16{imm[15]}}, imm};
	zImm = {16'd0, imm};
	case (op)
		opRType: begin
			case (fn)
				fnAdd, fnAddu: return a + b;
				fnSub, fnSubu: return a - b;
				fnAnd: return a & b;
				fnOr: return a | b;
				fnXor: return a ^ b;
				fnNor: return ~(a | b);
				fnSlt: return {31'd0, $signed(a) < $signed(b)};
				fnSltu: return {31'd0, a < b};
				default: return '0;
			endcase
		end
		opAddi, opAddiu: return a + sImm;
		opSlti: return {31'd0, $signed(a) < $signed(sImm)};
		opAndi: return a & zImm;
		opOri: return a | zImm;
		opXori: return a ^ zImm;
		opLui: return {imm, 16'd0};
		default: return '0;
	endcase
endfunction

function automatic logic branchRef(input opcodeField op, input dataWord a, input dataWord b);
	case (op)
		opBeq: return a == b;
		opBne: return a != b;
		opBgtz: return $signed(a) > 0;
		opBlez: return $signed(a) <= 0;
		default: return 1'b0;
	endcase
endfunction

`endif

// File: bench/mipsProcessorTb.sv
`timescale 1ns/1ps

module mipsProcessorTb;
	import isaPkg::*;
	import ctrlPkg::*;

	`include "isaModel.svh"

	localparam logic [1:0] kNone = 2'd0;
	localparam logic [1:0] kRead = 2'd1;
	localparam logic [1:0] kWrite = 2'd2;
	localparam logic [1:0] kReset = 2'd3;

	typedef struct packed {
		logic [1:0] kind;
		memAddr addr;
		dataWord data;
	} accessRec;

	logic CLK;
	logic reset;
	logic memReady;
	dataWord memReadData;
	memReq request;

	dataWord mem [128];
	accessRec accessQ [$];
	int pushCount = 0;
	int popCount = 0;
	int progLen = 0;
	int slot = 0;
	int cycleCount = 0;
	int cycleLimit = 100000;
	int resetLeft = 2;
	int dataErrors = 0;
	int protocolErrors = 0;
	logic finished = 1'b0;

	// Reference state
	dataWord modelRegs [32];
	memAddr modelPc;
	logic [1:0] expKind;
	memAddr expAddr;
	dataWord expData;
	int fetchCount = 0;
	int runIndex = 0;
	int spinCount = 0;
	memAddr spinAddr;

	mipsProcessor UUT (.CLK(CLK), .reset(reset), .memReadData(memReadData),
		.memReady(memReady), .memRequest(request));

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic emit(input dataWord word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic storeReg(input regAddr r);
		emit(encI(opSw, r, 5'd0, immField'(384 + 4 * slot)));
		slot++;
	endtask

	task automatic buildProgram();
		opcodeField immOps [7];
		functField rOps [10];
		immOps = '{opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui};
		rOps = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
		for (int i = 0; i < 128; i++) begin
			mem[i] = 32'h9E3779B9 * (i + 1);	// Whole-address fill
		end
		for (int r = 1; r <= 8; r++) begin
			emit(encI(opLui, regAddr'(r), 5'd0, immField'(takeBits(16))));
			emit(encI(opOri, regAddr'(r), regAddr'(r), immField'(takeBits(16))));
		end
		for (int k = 0; k < 10; k++) begin
			emit(encR(rOps[k], regAddr'(9 + k), regAddr'(1 + takeBits(3)),
				regAddr'(1 + takeBits(3))));
			storeReg(regAddr'(9 + k));
		end
		for (int k = 0; k < 7; k++) begin
			emit(encI(immOps[k], 5'd20, regAddr'(1 + takeBits(3)), immField'(takeBits(16))));
			storeReg(5'd20);
		end
		emit(encI(opLw, 5'd21, 5'd0, 16'd384));
		storeReg(5'd21);
		emit(encI(opAddi, 5'd22, 5'd0, immField'(400 + 4 * takeBits(3))));
		emit(encI(opLw, 5'd23, 5'd22, 16'hFFF8));	// Negative offset
		storeReg(5'd23);
		emit(encI(opAddi, 5'd24, 5'd0, immField'(1 + takeBits(4))));
		emit(encI(opAddi, 5'd25, 5'd0, -immField'(1 + takeBits(4))));
		emit(encI(opBeq, 5'd1, 5'd1, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd1));
		emit(encI(opBeq, 5'd24, 5'd25, 16'd1));	// Operands differ
		emit(encI(opAddi, 5'd27, 5'd27, 16'd64));
		emit(encI(opBne, 5'd1, 5'd1, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd2));
		emit(encI(opBgtz, 5'd0, 5'd24, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd4));
		emit(encI(opBgtz, 5'd0, 5'd25, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd8));
		emit(encI(opBlez, 5'd0, 5'd25, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd16));
		emit(encI(opBlez, 5'd0, 5'd24, 16'd1));
		emit(encI(opAddi, 5'd27, 5'd27, 16'd32));
		emit(encI(opAddi, 5'd26, 5'd0, 16'd3));
		emit(encI(opAddi, 5'd26, 5'd26, 16'hFFFF));
		emit(encI(opBne, 5'd0, 5'd26, 16'hFFFE));	// Back two words
		storeReg(5'd27);
		storeReg(5'd26);
		emit(encI(opAddi, 5'd0, 5'd0, immField'(1 + takeBits(15))));
		storeReg(5'd0);
		spinAddr = memAddr'(4 * progLen);
		emit(encI(opBeq, 5'd0, 5'd0, 16'hFFFF));
	endtask

	task automatic resetModel();
		foreach (modelRegs[i]) modelRegs[i] = '0;
		modelPc = '0;
		expKind = kNone;
	endtask

	task automatic executeModel(input dataWord instr);
		opcodeField op;
		regAddr rs, rt, rd;
		immField imm;
		dataWord ea;
		op = instr[31:26];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		imm = instr[15:0];
		ea = modelRegs[rs] + {{16{imm[15]}}, imm};
		modelPc = modelPc + 9'd4;
		case (op)
			opRType: modelRegs[rd] = refAlu(op, instr[5:0], modelRegs[rs], modelRegs[rt], imm);
			opAddi, opAddiu, opSlti, opAndi, opOri, opXori, opLui:
				modelRegs[rt] = refAlu(op, instr[5:0], modelRegs[rs], modelRegs[rt], imm);
			opLw: begin
				expKind = kRead;
				expAddr = ea[8:0];
				modelRegs[rt] = mem[ea[8:2]];
			end
			opSw: begin
				expKind = kWrite;
				expAddr = ea[8:0];
				expData = modelRegs[rt];
			end
			opBeq, opBne, opBgtz, opBlez: begin
				if (branchRef(op, modelRegs[rs], modelRegs[rt])) begin
					modelPc = modelPc + memAddr'({imm, 2'b00});
				end
			end
			default: ;
		endcase
		modelRegs[0] = '0;
	endtask

	task automatic pushAccess(input logic [1:0] kind, input memAddr addr, input dataWord data);
		accessQ.push_back('{kind: kind, addr: addr, data: data});
		pushCount++;
	endtask

	// Memory model, answers each strobe after a random delay
	initial begin
		memReq held;
		logic pending;
		logic acceptedLast;
		int waitLeft;
		pending = 1'b0;
		acceptedLast = 1'b0;
		waitLeft = 0;
		forever begin
			@(posedge CLK);
			#1;
			cycleCount++;
			memReady = 1'b0;
			if (resetLeft > 0) begin
				if (!reset) pushAccess(kReset, '0, '0);
				reset = 1'b1;
				resetLeft--;
				pending = 1'b0;
				acceptedLast = 1'b0;
			end else begin
				reset = 1'b0;
				if (acceptedLast && (request.read || request.write)) begin
					protocolErrors++;
					$display("Strobe still high the cycle after acceptance at %0t", $time);
				end
				acceptedLast = 1'b0;
				if (request.read || request.write) begin
					if (!pending) begin
						pending = 1'b1;
						held = request;
						waitLeft = takeBits(3) % 6;
					end else if (request != held) begin
						protocolErrors++;
						$display("MISMATCH %0t memRequest exp %h got %h", $time, held, request);
					end
					if (waitLeft == 0) begin
						memReady = 1'b1;
						pending = 1'b0;
						acceptedLast = 1'b1;
						memReadData = mem[request.addr[8:2]];
						if (request.write) begin
							mem[request.addr[8:2]] = request.writeData;
							pushAccess(kWrite, request.addr, request.writeData);
						end else begin
							pushAccess(kRead, request.addr, memReadData);
						end
					end else begin
						waitLeft--;
					end
				end
			end
		end
	end

	// Compares every bus access with the reference model
	initial begin
		accessRec rec;
		resetModel();
		forever begin
			wait (popCount < pushCount);
			rec = accessQ.pop_front();
			popCount++;
			if (rec.kind == kReset) begin
				resetModel();
				runIndex++;
				spinCount = 0;
			end else if (rec.kind == kWrite) begin
				if (expKind != kWrite) begin
					dataErrors++;
					$display("Unexpected store to %h at %0t", rec.addr, $time);
				end else begin
					if (rec.addr != expAddr) begin
						dataErrors++;
						$display("MISMATCH %0t store addr exp %h got %h", $time, expAddr, rec.addr);
					end
					if (rec.data != expData) begin
						dataErrors++;
						$display("MISMATCH %0t writeData exp %h got %h", $time, expData, rec.data);
					end
				end
				expKind = kNone;
			end else if (expKind == kRead) begin
				if (rec.addr != expAddr) begin
					dataErrors++;
					$display("MISMATCH %0t load addr exp %h got %h", $time, expAddr, rec.addr);
				end
				expKind = kNone;
			end else begin
				if (expKind == kWrite) begin
					dataErrors++;
					$display("Store expected but a read came at %0t", $time);
					expKind = kNone;
				end
				if (rec.addr != modelPc) begin
					dataErrors++;
					$display("MISMATCH %0t fetch addr exp %h got %h", $time, modelPc, rec.addr);
				end
				fetchCount++;
				if (rec.addr == spinAddr) spinCount++;
				executeModel(rec.data);
				if (runIndex == 0 && fetchCount == 64) resetLeft = 3;	// Mid-program reset once r27 is nonzero
				if (runIndex == 1 && spinCount >= 3) finished = 1'b1;
			end
		end
	end

	initial begin
		wait (cycleCount >= cycleLimit);
		$display("Timeout after %0d cycles without reaching the end loop", cycleCount);
		$display("Errors: %0d data, %0d protocol", dataErrors, protocolErrors);
		$display("Regression failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		memReady = 1'b0;
		memReadData = '0;
		buildProgram();
		cycleLimit = 2 * (progLen + 10) * 19 + 100;	// Two runs, worst-case cycles each
		wait (finished);
		@(posedge CLK);
		$display("Errors: %0d data, %0d protocol", dataErrors, protocolErrors);
		if (dataErrors == 0 && protocolErrors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: rtl/mipsProcessor.sv
`timescale 1ns/1ps

module mipsProcessor (
	input logic CLK,
	input logic reset,
	input isaPkg::dataWord memReadData,
	input logic memReady,
	output ctrlPkg::memReq memRequest
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlWord ctrl;
	logic memDone;
	dataWord readWord;	// MDR
	opcodeField opcode;
	functField funct;
	memAddr pcValue;
	dataWord aluResult;
	dataWord storeData;

	memPort bus (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl),
		.pcValue(pcValue),
		.aluResult(aluResult),
		.storeData(storeData),
		.memReadData(memReadData),
		.memReady(memReady),
		.memRequest(memRequest),
		.memDone(memDone),
		.readWord(readWord)
	);

	controlUnit control (.CLK(CLK), .reset(reset), .opcode(opcode), .funct(funct),
		.memDone(memDone), .ctrl(ctrl));

	dataPath datapath (.CLK(CLK), .reset(reset), .ctrl(ctrl), .readWord(readWord),
		.opcode(opcode), .funct(funct), .pcValue(pcValue), .aluResult(aluResult),
		.storeData(storeData));

endmodule

// File: rtl/dataPath.sv
`timescale 1ns/1ps

module dataPath (
	input logic CLK,
	input logic reset,
	input ctrlPkg::ctrlWord ctrl,
	input isaPkg::dataWord readWord,
	output isaPkg::opcodeField opcode,
	output isaPkg::functField funct,
	output isaPkg::memAddr pcValue,
	output isaPkg::dataWord aluResult,
	output isaPkg::dataWord storeData
);
	import isaPkg::*;
	import ctrlPkg::*;

	memAddr pc;
	dataWord ir;
	regAddr rs, rt, rd;
	regAddr destReg;
	immField imm;
	dataWord rsValue, rtValue;
	dataWord signImm, zeroImm;
	dataWord operandB;
	dataWord writeBack;
	logic taken;

	assign opcode = ir[31:26];
	assign rs = ir[25:21];
	assign rt = ir[20:16];
	assign rd = ir[15:11];
	assign imm = ir[15:0];
	assign funct = ir[5:0];

	assign signImm = {{16{imm[15]}}, imm};
	assign zeroImm = {16'b0, imm};	// ANDI, ORI, XORI, LUI

	always_comb begin
		case (ctrl.aluSrc)
			srcSignImm: operandB = signImm;
			srcZeroImm: operandB = zeroImm;
			default: operandB = rtValue;
		endcase
	end

	assign destReg = (ctrl.regDst == dstRd) ? rd : rt;
	assign writeBack = (ctrl.regIn == inMem) ? readWord : aluResult;

	// Branch compares register contents
	always_comb begin
		case (opcode)
			opBeq: taken = (rsValue == rtValue);
			opBne: taken = (rsValue != rtValue);
			opBgtz: taken = (signed'(rsValue) > 32'sd0);
			opBlez: taken = (signed'(rsValue) <= 32'sd0);
			default: taken = 1'b0;
		endcase
	end

	// PC already holds PC + 4 when a branch is evaluated
	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcLoad) begin
			pc <= pc + memAddr'(4);
		end else if (ctrl.branchEval && taken) begin
			pc <= pc + memAddr'({imm, 2'b00});	// Wraps at 512
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irLoad) begin
			ir <= readWord;
		end
	end

	registerFile regs (
		.CLK(CLK),
		.reset(reset),
		.readAddrA(rs),
		.readAddrB(rt),
		.writeAddr(destReg),
		.writeData(writeBack),
		.writeEnable(ctrl.regWrite),
		.readDataA(rsValue),
		.readDataB(rtValue)
	);

	alu mainAlu (
		.op(ctrl.alu),
		.a(rsValue),
		.b(operandB),
		.result(aluResult)
	);

	assign pcValue = pc;
	assign storeData = rtValue;	// SW writes rt

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu (
	input ctrlPkg::aluOp op,
	input isaPkg::dataWord a,
	input isaPkg::dataWord b,
	output isaPkg::dataWord result
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		case (op)
			aluAdd: begin
				result = a + b;	// Wraps, no overflow trap
			end
			aluSub: begin
				result = a - b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluXor: begin
				result = a ^ b;
			end
			aluNor: begin
				result = ~(a | b);
			end
			aluSlt: begin
				result = dataWord'(signed'(a) < signed'(b));
			end
			aluSltu: begin
				result = dataWord'(a < b);
			end
			aluLui: begin
				result = {b[15:0], 16'b0};	// Immediate into upper half
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic CLK,
	input logic reset,
	input isaPkg::regAddr readAddrA,
	input isaPkg::regAddr readAddrB,
	input isaPkg::regAddr writeAddr,
	input isaPkg::dataWord writeData,
	input logic writeEnable,
	output isaPkg::dataWord readDataA,
	output isaPkg::dataWord readDataB
);
	import isaPkg::*;

	dataWord regs [regCount];

	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// R0 is hardwired to zero
	assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input logic CLK,
	input logic reset,
	input isaPkg::opcodeField opcode,
	input isaPkg::functField funct,
	input logic memDone,
	output ctrlPkg::ctrlWord ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	cpuState state;
	cpuState nextState;
	logic validOp;	// Known opcode
	logic writesReg;	// ALU result goes to a register
	logic isBranch;
	logic isLoad;
	logic isStore;
	aluOp opAlu;
	aluSrcSel srcSel;
	regDstSel dstSel;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= sFetchReq;
		end else begin
			state <= nextState;
		end
	end

	// Instruction decode
	always_comb begin
		validOp = 1'b1;
		writesReg = 1'b1;
		isBranch = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		opAlu = aluAdd;
		srcSel = srcSignImm;
		dstSel = dstRt;
		case (opcode)
			opRType: begin
				srcSel = srcReg;
				dstSel = dstRd;
				case (funct)
					fnAdd, fnAddu: opAlu = aluAdd;
					fnSub, fnSubu: opAlu = aluSub;
					fnAnd: opAlu = aluAnd;
					fnOr: opAlu = aluOr;
					fnXor: opAlu = aluXor;
					fnNor: opAlu = aluNor;
					fnSlt: opAlu = aluSlt;
					fnSltu: opAlu = aluSltu;
					default: writesReg = 1'b0;	// Unknown funct does nothing
				endcase
			end
			opAddi, opAddiu: opAlu = aluAdd;
			opSlti: opAlu = aluSlt;
			opAndi: {opAlu, srcSel} = {aluAnd, srcZeroImm};
			opOri: {opAlu, srcSel} = {aluOr, srcZeroImm};
			opXori: {opAlu, srcSel} = {aluXor, srcZeroImm};
			opLui: {opAlu, srcSel} = {aluLui, srcZeroImm};
			opLw: {isLoad, writesReg} = 2'b10;	// Written later from memory
			opSw: {isStore, writesReg} = 2'b10;
			opBeq, opBne, opBgtz, opBlez: {isBranch, writesReg} = 2'b10;
			default: {validOp, writesReg} = 2'b00;
		endcase
	end

	always_comb begin
		nextState = state;
		case (state)
			sFetchReq: nextState = sFetchWait;
			sFetchWait: if (memDone) nextState = sDecode;
			sDecode: nextState = validOp ? sExecute : sFetchReq;
			sExecute: nextState = isLoad ? sLoadReq : (isStore ? sStoreReq : sFetchReq);
			sLoadReq: nextState = sLoadWait;
			sLoadWait: if (memDone) nextState = sFetchReq;
			sStoreReq: nextState = sStoreWait;
			sStoreWait: if (memDone) nextState = sFetchReq;
			default: nextState = sFetchReq;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu = opAlu;
		ctrl.aluSrc = srcSel;
		ctrl.regDst = dstSel;
		ctrl.regIn = inAlu;
		case (state)
			sFetchReq: ctrl.memStart = 1'b1;
			sFetchWait: ctrl.irLoad = memDone;
			sDecode: ctrl.pcLoad = 1'b1;
			sExecute: {ctrl.regWrite, ctrl.branchEval} = {writesReg, isBranch};
			sLoadReq: {ctrl.memStart, ctrl.addrFromAlu} = 2'b11;
			sLoadWait: {ctrl.regWrite, ctrl.regIn} = {memDone, inMem};	// LW targets rt
			sStoreReq: {ctrl.memStart, ctrl.memWrite, ctrl.addrFromAlu} = 3'b111;
			default: ;
		endcase
	end

endmodule

// File: rtl/memPort.sv
`timescale 1ns/1ps

module memPort (
	input logic CLK,
	input logic reset,
	input ctrlPkg::ctrlWord ctrl,
	input isaPkg::memAddr pcValue,
	input isaPkg::dataWord aluResult,
	input isaPkg::dataWord storeData,
	input isaPkg::dataWord memReadData,
	input logic memReady,
	output ctrlPkg::memReq memRequest,
	output logic memDone,
	output isaPkg::dataWord readWord
);
	import isaPkg::*;

	logic readReq;
	logic writeReq;
	memAddr addrReg;
	dataWord dataReg;

	assign memDone = (readReq | writeReq) & memReady;	// Accepting edge

	// Strobes rise the cycle after memStart and drop after acceptance
	always_ff @(posedge CLK) begin
		if (reset) begin
			readReq <= 1'b0;
			writeReq <= 1'b0;
		end else if (ctrl.memStart) begin
			readReq <= ~ctrl.memWrite;
			writeReq <= ctrl.memWrite;
		end else if (memDone) begin
			readReq <= 1'b0;
			writeReq <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.memStart) begin
			addrReg <= ctrl.addrFromAlu ? aluResult[addrWidth-1:0] : pcValue;
			dataReg <= storeData;	// Held until accepted
		end
	end

	// IR and load writeback take the word on the accepting edge itself
	assign readWord = memReadData;

	assign memRequest = '{
		addr: addrReg,
		writeData: dataReg,
		read: readReq,
		write: writeReq
	};

endmodule

// File: rtl/ctrlPkg.sv
package ctrlPkg;

	typedef enum logic [2:0] {
		sFetchReq,
		sFetchWait,
		sDecode,
		sExecute,
		sLoadReq,
		sLoadWait,
		sStoreReq,
		sStoreWait
	} cpuState;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu, aluLui
	} aluOp;

	typedef enum logic [1:0] {srcReg, srcSignImm, srcZeroImm} aluSrcSel;
	typedef enum logic {dstRt, dstRd} regDstSel;
	typedef enum logic {inAlu, inMem} regInSel;

	typedef struct packed {
		logic memStart;	// Launch a bus request
		logic memWrite;	// Direction of that request
		logic addrFromAlu;	// Data access, else fetch
		logic irLoad;
		logic pcLoad;	// PC + 4
		logic branchEval;
		logic regWrite;
		regDstSel regDst;
		regInSel regIn;
		aluSrcSel aluSrc;
		aluOp alu;
	} ctrlWord;

	typedef struct packed {
		isaPkg::memAddr addr;
		isaPkg::dataWord writeData;
		logic read;
		logic write;
	} memReq;

endpackage

// File: rtl/isaPkg.sv
package isaPkg;

	localparam int dataWidth = 32;	// Register and memory word
	localparam int regCount = 32;
	localparam int addrWidth = 9;	// 512-byte address space

	typedef logic [dataWidth-1:0] dataWord;
	typedef logic [addrWidth-1:0] memAddr;
	typedef logic [$clog2(regCount)-1:0] regAddr;
	typedef logic [5:0] opcodeField;	// IR[31:26]
	typedef logic [5:0] functField;	// IR[5:0]
	typedef logic [15:0] immField;

	// Primary opcodes
	localparam opcodeField opRType = 6'h00;
	localparam opcodeField opBeq = 6'h04;
	localparam opcodeField opBne = 6'h05;
	localparam opcodeField opBlez = 6'h06;
	localparam opcodeField opBgtz = 6'h07;
	localparam opcodeField opAddi = 6'h08;
	localparam opcodeField opAddiu = 6'h09;
	localparam opcodeField opSlti = 6'h0A;
	localparam opcodeField opAndi = 6'h0C;
	localparam opcodeField opOri = 6'h0D;
	localparam opcodeField opXori = 6'h0E;
	localparam opcodeField opLui = 6'h0F;
	localparam opcodeField opLw = 6'h23;
	localparam opcodeField opSw = 6'h2B;

	// R-type funct codes
	localparam functField fnAdd = 6'h20;
	localparam functField fnAddu = 6'h21;
	localparam functField fnSub = 6'h22;
	localparam functField fnSubu = 6'h23;
	localparam functField fnAnd = 6'h24;
	localparam functField fnOr = 6'h25;
	localparam functField fnXor = 6'h26;
	localparam functField fnNor = 6'h27;
	localparam functField fnSlt = 6'h2A;
	localparam functField fnSltu = 6'h2B;

endpackage
